// File: Makefile
TOP = mmuTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f mmu.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only --timing -f mmu.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: bench/mmuTb.sv
module mmuTb;
  timeunit 1ns;
  timeprecision 1ps;
  import mmuPkg::*;

  logic clk, reset, mmuEnable, sBit, rBit, cpuRequest, cpuWrite, supMode, wordAccess;
  logic [TBASE_W-1:0] tableBase;
  addrT domainAccess, cpuAddr, busReadData, busAddr, cp15WriteData;
  logic cpuReady, busReady, busRequest, busWrite, cp15WriteEn, dataAbort;
  logic [3:0] cp15Addr;

  addrT   tableMem [addrT];  // Table entries only, data reads return ~address
  addrT   lastData;
  logic   lastWrite;
  integer seed = 32'h864b_5b68;
  int     waitLeft = 0;
  logic   reqSeen = 1'b0;
  int     tableCount = 0, dataCount = 0, valueErrors = 0, otherErrors = 0;

  mmu u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ====================
  // Bus memory model
  // ====================
  always @(posedge clk) begin
    reqSeen <= busRequest;
    if (busRequest && busReady) begin
      if (tableMem.exists(busAddr)) begin
        tableCount++;
        if (busWrite) begin
          $display("Table fetch at %h was issued as a write", busAddr);
          otherErrors++;
        end
      end else begin
        dataCount++;
        lastData  = busAddr;
        lastWrite = busWrite;
      end
    end
  end

  always @(negedge clk) begin
    if (busReady) begin
      busReady <= 1'b0;
      waitLeft <= $unsigned($random(seed)) % 3;  // 0 to 2 wait cycles
    end else if (reqSeen) begin
      if (waitLeft == 0) begin
        busReady    <= 1'b1;
        busReadData <= tableMem.exists(busAddr) ? tableMem[busAddr] : ~busAddr;
      end else waitLeft <= waitLeft - 1;
    end
  end

  function automatic addrT l1Entry(input addrT va);
    return {tableBase, va[31:20], 2'b00};
  endfunction

  function automatic addrT sectionDesc(input logic [11:0] phys, input logic [3:0] dom,
                                       input logic [1:0] ap);
    return {phys, 8'h00, ap, 1'b0, dom, 3'b000, DESC_SECTION};
  endfunction

  // Expected outcome of the AP rule for a client domain
  function automatic logic apAllows(input logic [1:0] ap, input logic s, r, sup, wr);
    case (ap)
      2'b11:   return 1'b1;
      2'b10:   return sup || !wr;
      2'b01:   return sup;
      default: return !wr && ((s && !r && sup) || (r && !s));
    endcase
  endfunction

  task automatic finishRun();
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  task automatic compareAddr(input addrT got, input addrT exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
      valueErrors++;
    end
  endtask

  task automatic compareFault(input faultCodeT got, input faultCodeT exp);
    if (got !== exp) begin
      $display("ERROR at %0t: fault code got %b expected %s", $time, got, exp.name());
      valueErrors++;
    end
  endtask

  task automatic compareFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
      valueErrors++;
    end
  endtask

  // Runs one CPU access until cpuReady or dataAbort
  task automatic doAccess(input addrT va, input logic wr, sup, word, output logic aborted);
    int   cycles;
    logic done;
    @(negedge clk);
    cpuAddr    = va;
    cpuWrite   = wr;
    supMode    = sup;
    wordAccess = word;
    cpuRequest = 1'b1;
    done       = 1'b0;
    aborted    = 1'b0;
    cycles     = 0;
    while (!done && cycles < 40) begin
      @(posedge clk);
      cycles++;
      if (dataAbort) begin
        aborted = 1'b1;
        done    = 1'b1;
      end else if (cpuReady) done = 1'b1;
    end
    if (!done) begin
      $display("Timeout: neither cpuReady nor dataAbort came for address %h", va);
      otherErrors++;
      finishRun();
    end else begin
      @(negedge clk);
      cpuRequest = 1'b0;
    end
  endtask

  task automatic expectOk(input addrT va, input logic wr, sup, word, input addrT phys,
                          input int fetches);
    int   dBefore;
    int   tBefore;
    logic aborted;
    dBefore = dataCount;
    tBefore = tableCount;
    doAccess(va, wr, sup, word, aborted);
    if (aborted) begin
      $display("Unexpected data abort at address %h", va);
      otherErrors++;
    end else if (dataCount != dBefore + 1) begin
      $display("Access to %h finished without a data transfer", va);
      otherErrors++;
    end else begin
      compareAddr(lastData, phys, "data address");
      compareFlag(lastWrite, wr, "bus write");
    end
    if (tableCount - tBefore != fetches) begin
      $display("ERROR at %0t: %0d table fetches expected %0d", $time,
               tableCount - tBefore, fetches);
      valueErrors++;
    end
  endtask

  task automatic expectFault(input addrT va, input logic wr, sup, word,
                             input faultCodeT code, input logic [3:0] dom);
    int   dBefore;
    logic aborted;
    dBefore = dataCount;
    doAccess(va, wr, sup, word, aborted);
    if (!aborted) begin
      $display("No data abort for address %h", va);
      otherErrors++;
    end else begin
      @(posedge clk);
      if (dataAbort || !cp15WriteEn || cp15Addr != CP15_FSR) begin
        $display("FSR write missing or abort repeated for address %h", va);
        otherErrors++;
      end
      compareFault(faultCodeT'(cp15WriteData[3:0]), code);
      compareAddr(cp15WriteData, {24'h0, dom, code}, "FSR data");
      @(posedge clk);
      if (!cp15WriteEn || cp15Addr != CP15_FAR) begin
        $display("FAR write missing for address %h", va);
        otherErrors++;
      end
      compareAddr(cp15WriteData, va, "FAR data");
    end
    if (dataCount != dBefore) begin
      $display("Data transfer happened despite a fault at %h", va);
      otherErrors++;
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic testDisabled();
    @(negedge clk);
    mmuEnable = 1'b0;
    expectOk(32'h1234_5678, 1'b0, 1'b0, 1'b1, 32'h1234_5678, 0);
    expectOk(32'h0030_0001, 1'b1, 1'b0, 1'b1, 32'h0030_0001, 0);  // No faults when off
    mmuEnable = 1'b1;
  endtask

  task automatic testSections();
    tableMem[l1Entry(32'h0010_0000)] = sectionDesc(12'h800, 4'd1, 2'b11);
    tableMem[l1Entry(32'h0060_0000)] = sectionDesc(12'h870, 4'd3, 2'b00);
    expectOk(32'h0010_0ABC, 1'b0, 1'b0, 1'b1, 32'h8000_0ABC, 1);
    expectOk(32'h001F_FFF0, 1'b1, 1'b0, 1'b1, 32'h800F_FFF0, 1);
    expectOk(32'h0060_1234, 1'b1, 1'b0, 1'b1, 32'h8700_1234, 1);  // Manager domain
  endtask

  task automatic testPages();
    tableMem[l1Entry(32'h0020_0000)] = 32'h0008_0000 | (2 << 5) | DESC_COARSE;
    tableMem[32'h0008_0004] = 32'h9001_21B2;  // Subpage APs 11, 10, 01, 00
    tableMem[32'h0008_0080] = 32'h0000_0000;
    for (int i = 16; i < 32; i++) tableMem[32'h0008_0000 + i * 4] = 32'hA005_01B1;
    for (int sub = 0; sub < 4; sub++) begin
      if (sub == 0) expectOk(32'h0020_1010, 1'b1, 1'b0, 1'b1, 32'h9001_2010, 2);
      else expectFault(32'h0020_1010 + sub * 32'h400, 1'b1, 1'b0, 1'b1, PPFAULT, 4'd2);
      if (sub < 2) expectOk(32'h0021_0020 + sub * 32'h4000, 1'b0, 1'b0, 1'b1,
                            32'hA005_0020 + sub * 32'h4000, 2);
      else expectFault(32'h0021_0020 + sub * 32'h4000, 1'b0, 1'b0, 1'b1, PPFAULT, 4'd2);
    end
    expectOk(32'h0021_B004, 1'b0, 1'b1, 1'b1, 32'hA005_B004, 2);  // Supervisor-only subpage
  endtask

  task automatic testFaults();
    tableMem[l1Entry(32'h0030_0000)] = 32'h0000_0060;  // Type 00, domain 3
    tableMem[l1Entry(32'h0040_0000)] = sectionDesc(12'h840, 4'd4, 2'b11);
    tableMem[l1Entry(32'h0050_0000)] = 32'h000C_0000 | (4 << 5) | DESC_COARSE;
    tableMem[32'h000C_0000] = 32'hB000_0FF2;
    expectFault(32'h0030_0010, 1'b0, 1'b1, 1'b1, TSFAULT, 4'd3);
    expectFault(32'h0022_0040, 1'b0, 1'b1, 1'b1, TPFAULT, 4'd2);
    expectFault(32'h0040_0100, 1'b1, 1'b1, 1'b1, DSFAULT, 4'd4);
    expectFault(32'h0050_0200, 1'b0, 1'b1, 1'b1, DPFAULT, 4'd4);
  endtask

  task automatic testAlignment();
    int tBefore;
    tBefore = tableCount;
    expectFault(32'h0010_0002, 1'b0, 1'b1, 1'b1, ALIGNFAULT, 4'd0);
    if (tableCount != tBefore) begin
      $display("Table fetch started for a misaligned access");
      otherErrors++;
    end
    expectOk(32'h0010_0003, 1'b0, 1'b1, 1'b0, 32'h8000_0003, 1);  // Byte access is fine
  endtask

  task automatic testPermissions();
    for (int ap = 0; ap < 4; ap++) begin
      tableMem[l1Entry(32'h0010_0000)] = sectionDesc(12'h800, 4'd1, ap[1:0]);
      for (int sr = 0; sr < 4; sr++) begin
        @(negedge clk);
        sBit = sr[1];
        rBit = sr[0];
        for (int mode = 0; mode < 4; mode++) begin
          if (apAllows(ap[1:0], sr[1], sr[0], mode[1], mode[0]))
            expectOk(32'h0010_0ABC, mode[0], mode[1], 1'b1, 32'h8000_0ABC, 1);
          else expectFault(32'h0010_0ABC, mode[0], mode[1], 1'b1, PSFAULT, 4'd1);
        end
      end
    end
  endtask

  initial begin
    reset        = 1'b1;
    mmuEnable    = 1'b1;
    sBit         = 1'b0;
    rBit         = 1'b0;
    tableBase    = 18'h00010;
    domainAccess = 32'h0000_00D5;  // Domains 0..2 client, 3 manager, 4 no access
    cpuRequest   = 1'b0;
    cpuWrite     = 1'b0;
    cpuAddr      = '0;
    supMode      = 1'b0;
    wordAccess   = 1'b0;
    busReady     = 1'b0;
    busReadData  = '0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    @(posedge clk);
    if (busRequest || cpuReady || dataAbort || cp15WriteEn) begin
      $display("Outputs not idle after reset");
      otherErrors++;
    end
    testDisabled();
    testSections();
    testPages();
    testFaults();
    testAlignment();
    testPermissions();
    repeat (3) @(negedge clk);
    finishRun();
  end

endmodule

// File: bench/mmu_asserts.sv
module mmuAsserts (
  input logic         clk,
  input logic         reset,
  input logic         dataAbort,
  input logic         cp15WriteEn,
  input logic [3:0]   cp15Addr,
  input logic         busRequest,
  input logic         busReady,
  input mmuPkg::addrT busAddr
);
  timeunit 1ns;
  timeprecision 1ps;
  import mmuPkg::*;

  // Every cp15 write belongs to an abort report
  cp15Target: assert property (@(posedge clk) disable iff (reset)
    cp15WriteEn |-> (cp15Addr == CP15_FSR && $past(dataAbort)) ||
                    (cp15Addr == CP15_FAR && $past(cp15WriteEn && cp15Addr == CP15_FSR)))
    else $error("cp15 write to register %0d outside an abort report", cp15Addr);

  abortSequence: assert property (@(posedge clk) disable iff (reset)
    dataAbort |=> (cp15WriteEn && cp15Addr == CP15_FSR) ##1
                  (cp15WriteEn && cp15Addr == CP15_FAR))
    else $error("abort not followed by FSR then FAR write");

  // Address holds through wait states
  addrHold: assert property (@(posedge clk) disable iff (reset)
    busRequest && !busReady |=> $stable(busAddr))
    else $error("busAddr changed during a wait state");

endmodule

bind mmu mmuAsserts u_asserts (.*);

// File: logic/accessChecker.sv
module accessChecker (
  input  logic              clk,
  input  logic              reset,
  input  mmuPkg::walkStateT walkState,
  input  mmuPkg::addrT      firstDesc,
  input  mmuPkg::addrT      pageDesc,
  input  mmuPkg::addrT      domainAccess,
  input  mmuPkg::addrT      cpuAddr,
  input  logic              sBit,
  input  logic              rBit,
  input  logic              supMode,
  input  logic              cpuWrite,
  output logic              domainFault,
  output logic              permFault,
  output logic [3:0]        faultDomain
);
  import mmuPkg::*;

  logic [3:0] domainReg;
  logic [1:0] rights;
  logic [1:0] ap;
  logic [1:0] subSel;
  logic       firstLevel;
  logic       inTrans;
  logic       apFault;

  assign firstLevel = (walkState == SECTIONTRANS) || (walkState == COARSEFETCH);
  assign inTrans    = (walkState == SECTIONTRANS) || (walkState == SMALLTRANS) ||
                      (walkState == LARGETRANS);

  // ====================
  // Domain lookup
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      domainReg <= '0;
    end else if (firstLevel) begin
      domainReg <= firstDesc[8:5];
    end
  end

  // Fresh descriptor field on the first cycle, held copy for page states
  assign faultDomain = firstLevel ? firstDesc[8:5] : domainReg;
  assign rights      = domainAccess[{faultDomain, 1'b0} +: 2];

  // ====================
  // Access permissions
  // ====================
  assign subSel = (walkState == LARGETRANS) ? cpuAddr[15:14] : cpuAddr[11:10];

  always_comb begin
    case (walkState)
      SECTIONTRANS: ap = firstDesc[11:10];
      SMALLTRANS, LARGETRANS: begin
        case (subSel)
          2'd0:    ap = pageDesc[5:4];
          2'd1:    ap = pageDesc[7:6];
          2'd2:    ap = pageDesc[9:8];
          default: ap = pageDesc[11:10];
        endcase
      end
      default: ap = 2'b11;
    endcase
  end

  always_comb begin
    case (ap)
      2'b11: apFault = 1'b0;                  // Full access
      2'b10: apFault = !supMode && cpuWrite;  // User read-only
      2'b01: apFault = !supMode;              // Supervisor only
      default: begin
        case ({sBit, rBit})
          2'b10:   apFault = !supMode || cpuWrite;  // Supervisor reads only
          2'b01:   apFault = cpuWrite;              // Reads in any mode
          default: apFault = 1'b1;
        endcase
      end
    endcase
  end

  assign domainFault = inTrans && (rights == 2'b00);
  assign permFault   = inTrans && (rights == 2'b01) && apFault;  // Client only

endmodule

// File: logic/faultReporter.sv
module faultReporter (
  input  logic              clk,
  input  logic              reset,
  input  logic              mmuEnable,
  input  logic              cpuRequest,
  input  logic              wordAccess,
  input  mmuPkg::addrT      cpuAddr,
  input  mmuPkg::walkStateT walkState,
  input  logic              pageInvalid,
  input  logic              domainFault,
  input  logic              permFault,
  input  logic [3:0]        faultDomain,
  input  mmuPkg::addrT      firstDesc,
  input  logic              busReady,
  output logic              fault,
  output logic              reportBusy,
  output logic              dataAbort,
  output logic              cp15WriteEn,
  output logic [3:0]        cp15Addr,
  output mmuPkg::addrT      cp15WriteData
);
  import mmuPkg::*;

  reportStateT reportState;
  faultCodeT   faultCode;
  faultCodeT   codeReg;
  logic [3:0]  domReg;
  addrT        addrReg;
  logic        detected;
  logic        isSection;
  logic        transReq;

  assign isSection = (walkState == SECTIONTRANS);
  assign transReq  = cpuRequest && (isSection || (walkState == SMALLTRANS) ||
                                    (walkState == LARGETRANS));

  // ====================
  // Fault priority
  // ====================
  always_comb begin
    detected  = 1'b1;
    faultCode = ALIGNFAULT;
    if (walkState == READY && cpuRequest && wordAccess && cpuAddr[1:0] != 2'b00) begin
      faultCode = ALIGNFAULT;
    end else if (isSection && cpuRequest && firstDesc[1:0] == DESC_FAULT) begin
      faultCode = TSFAULT;
    end else if (pageInvalid && busReady) begin
      faultCode = TPFAULT;
    end else if (transReq && domainFault) begin
      faultCode = isSection ? DSFAULT : DPFAULT;
    end else if (transReq && permFault) begin
      faultCode = isSection ? PSFAULT : PPFAULT;
    end else begin
      detected = 1'b0;
    end
  end

  // One report at a time
  assign fault     = mmuEnable && detected && (reportState == IDLE);
  assign dataAbort = fault;

  // ====================
  // Status write sequence
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      reportState <= IDLE;
    end else begin
      case (reportState)
        IDLE:     if (fault) reportState <= WRITEFSR;
        WRITEFSR: reportState <= WRITEFAR;
        default:  reportState <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fault) begin
      codeReg <= faultCode;
      domReg  <= (faultCode == ALIGNFAULT) ? 4'h0 : faultDomain;  // No domain yet
      addrReg <= cpuAddr;
    end
  end

  assign reportBusy    = (reportState != IDLE);
  assign cp15WriteEn   = reportBusy;
  assign cp15Addr      = (reportState == WRITEFAR) ? CP15_FAR : CP15_FSR;
  assign cp15WriteData = (reportState == WRITEFAR) ? addrReg :
                         {{(ADDR_W-8){1'b0}}, domReg, codeReg};

endmodule

// File: logic/mmu.sv
module mmu (
  input  logic                       clk,
  input  logic                       reset,
  // CPU side
  input  logic                       mmuEnable,
  input  logic                       sBit,
  input  logic                       rBit,
  input  logic [mmuPkg::TBASE_W-1:0] tableBase,
  input  mmuPkg::addrT               domainAccess,
  input  logic                       cpuRequest,
  input  logic                       cpuWrite,
  input  mmuPkg::addrT               cpuAddr,
  input  logic                       supMode,
  input  logic                       wordAccess,
  output logic                       cpuReady,
  // Bus side
  input  logic                       busReady,
  input  mmuPkg::addrT               busReadData,
  output mmuPkg::addrT               busAddr,
  output logic                       busRequest,
  output logic                       busWrite,
  // Coprocessor side
  output logic                       cp15WriteEn,
  output logic [3:0]                 cp15Addr,
  output mmuPkg::addrT               cp15WriteData,
  output logic                       dataAbort
);
  import mmuPkg::*;

  walkStateT  walkState;
  addrT       firstDesc;
  addrT       pageDesc;
  logic       pageInvalid;
  logic       domainFault;
  logic       permFault;
  logic [3:0] faultDomain;
  logic       fault;
  logic       reportBusy;

  tableWalker u_walker (
    .clk, .reset, .mmuEnable, .cpuRequest, .cpuWrite, .busReady,
    .fault, .reportBusy, .tableBase, .cpuAddr, .busReadData,
    .busAddr, .busRequest, .busWrite, .cpuReady,
    .walkState, .firstDesc, .pageDesc, .pageInvalid
  );

  // Works on the same descriptors as the walker
  accessChecker u_checker (
    .clk, .reset, .walkState, .firstDesc, .pageDesc, .domainAccess,
    .cpuAddr, .sBit, .rBit, .supMode, .cpuWrite,
    .domainFault, .permFault, .faultDomain
  );

  faultReporter u_reporter (
    .clk, .reset, .mmuEnable, .cpuRequest, .wordAccess, .cpuAddr,
    .walkState, .pageInvalid, .domainFault, .permFault, .faultDomain,
    .firstDesc, .busReady,
    .fault, .reportBusy, .dataAbort, .cp15WriteEn, .cp15Addr, .cp15WriteData
  );

endmodule

// File: logic/mmuPkg.sv
package mmuPkg;

  // ====================
  // Widths
  // ====================
  localparam int ADDR_W  = 32;
  localparam int TBASE_W = 18;  // Table base, 16 KB aligned

  typedef logic [ADDR_W-1:0] addrT;

  // ====================
  // Descriptor codes
  // ====================
  // First-level type field, bits 1..0
  localparam logic [1:0] DESC_FAULT   = 2'b00;
  localparam logic [1:0] DESC_COARSE  = 2'b01;
  localparam logic [1:0] DESC_SECTION = 2'b10;

  localparam logic [1:0] PAGE_LARGE = 2'b01;  // Second level, 1x is a small page

  // Coprocessor registers
  localparam logic [3:0] CP15_FSR = 4'd5;
  localparam logic [3:0] CP15_FAR = 4'd6;

  // ====================
  // States and codes
  // ====================
  typedef enum logic [3:0] {
    READY,
    SECTIONTRANS,
    COARSEFETCH,
    SMALLTRANS,
    LARGETRANS
  } walkStateT;

  typedef enum logic [1:0] {
    IDLE,
    WRITEFSR,
    WRITEFAR
  } reportStateT;

  // Listed in priority order
  typedef enum logic [3:0] {
    ALIGNFAULT = 4'b0001,
    TSFAULT    = 4'b0101,
    TPFAULT    = 4'b0111,
    DSFAULT    = 4'b1001,
    DPFAULT    = 4'b1011,
    PSFAULT    = 4'b1101,
    PPFAULT    = 4'b1111
  } faultCodeT;

endpackage

// File: logic/tableWalker.sv
module tableWalker (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       mmuEnable,
  input  logic                       cpuRequest,
  input  logic                       cpuWrite,
  input  logic                       busReady,
  input  logic                       fault,
  input  logic                       reportBusy,
  input  logic [mmuPkg::TBASE_W-1:0] tableBase,
  input  mmuPkg::addrT               cpuAddr,
  input  mmuPkg::addrT               busReadData,
  output mmuPkg::addrT               busAddr,
  output logic                       busRequest,
  output logic                       busWrite,
  output logic                       cpuReady,
  output mmuPkg::walkStateT          walkState,
  output mmuPkg::addrT               firstDesc,
  output mmuPkg::addrT               pageDesc,
  output logic                       pageInvalid
);
  import mmuPkg::*;

  walkStateT nextState;
  addrT      walkAddr;
  logic      walkRequest;
  logic      walkWrite;
  logic      walkReady;
  logic      inTrans;

  assign inTrans = (walkState == SECTIONTRANS) || (walkState == SMALLTRANS) ||
                   (walkState == LARGETRANS);

  // ====================
  // Walk state machine
  // ====================
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      walkState <= READY;
    end else begin
      walkState <= nextState;
    end
  end

  always_comb begin
    nextState = walkState;
    case (walkState)
      READY: begin
        if (walkRequest && busReady) begin
          case (busReadData[1:0])
            DESC_COARSE:              nextState = COARSEFETCH;
            DESC_FAULT, DESC_SECTION: nextState = SECTIONTRANS;  // Type 00 faults there
            default:                  nextState = SECTIONTRANS;  // No fine tables
          endcase
        end
      end
      COARSEFETCH: begin
        if (busReady) begin
          if (pageInvalid) nextState = READY;
          else if (busReadData[1:0] == PAGE_LARGE) nextState = LARGETRANS;
          else nextState = SMALLTRANS;
        end
      end
      SECTIONTRANS, SMALLTRANS, LARGETRANS: begin
        if (fault || busReady || !cpuRequest) nextState = READY;
      end
      default: nextState = READY;
    endcase
    if (!mmuEnable) nextState = READY;
  end

  // Descriptor registers, filled as each fetch completes
  always_ff @(posedge clk) begin
    if (walkState == READY && walkRequest && busReady) firstDesc <= busReadData;
    if (walkState == COARSEFETCH && busReady) pageDesc <= busReadData;
  end

  // Second-level type 00 on the read bus
  assign pageInvalid = (walkState == COARSEFETCH) && (busReadData[1:0] == DESC_FAULT);

  // ====================
  // Bus address and control
  // ====================
  always_comb begin
    case (walkState)
      READY:        walkAddr = {tableBase, cpuAddr[31:20], 2'b00};
      SECTIONTRANS: walkAddr = {firstDesc[31:20], cpuAddr[19:0]};
      COARSEFETCH:  walkAddr = {firstDesc[31:10], cpuAddr[19:12], 2'b00};
      SMALLTRANS:   walkAddr = {pageDesc[31:12], cpuAddr[11:0]};
      LARGETRANS:   walkAddr = {pageDesc[31:16], cpuAddr[15:0]};
      default:      walkAddr = '0;
    endcase
  end

  always_comb begin
    case (walkState)
      READY:       walkRequest = cpuRequest && !reportBusy && !fault;
      COARSEFETCH: walkRequest = 1'b1;  // Table fetch runs to completion
      default:     walkRequest = inTrans && cpuRequest && !fault;
    endcase
  end

  assign walkWrite = inTrans && cpuWrite;   // Table fetches are reads
  assign walkReady = inTrans && busReady && !fault;

  // Bypass when translation is off
  assign busAddr    = mmuEnable ? walkAddr : cpuAddr;
  assign busRequest = mmuEnable ? walkRequest : cpuRequest;
  assign busWrite   = mmuEnable ? walkWrite : cpuWrite;
  assign cpuReady   = mmuEnable ? walkReady : busReady;

endmodule

// File: mmu.f
logic/mmuPkg.sv
logic/tableWalker.sv
logic/accessChecker.sv
logic/faultReporter.sv
logic/mmu.sv
bench/mmu_asserts.sv
bench/mmuTb.sv
